//--- opn_pkg.sv
/*
 * Shared types and constants for the FM sound chip control logic.
 * Widths of the CPU bus and timers, the register numbers of the timer
 * block and the default divider and busy settings used by the top level.
 */
package opn_pkg;

    // Bus and register widths
    typedef logic [7:0] cpu_data_t;
    typedef logic [1:0] port_addr_t;
    typedef logic [7:0] reg_num_t;

    // Timer value and count widths
    typedef logic [9:0] timer_a_t;
    typedef logic [7:0] timer_b_t;

    // Timer block register numbers
    localparam reg_num_t REG_TIMER_A_HI = 8'h24;  // Value A bits 9..2
    localparam reg_num_t REG_TIMER_A_LO = 8'h25;  // Value A bits 1..0
    localparam reg_num_t REG_TIMER_B    = 8'h26;
    localparam reg_num_t REG_TIMER_CTL  = 8'h27;  // Load, enable and clear bits

    // Default clocking
    localparam int DEF_PRESCALE     = 6;   // cen pulses per internal enable
    localparam int DEF_SAMPLE_SLOTS = 24;  // Internal enables per sample

    // Timer B runs slower than timer A
    localparam int DEF_TIMER_B_DIV  = 16;

    // Busy time after each data write, in cen cycles
    localparam int DEF_BUSY_CYCLES  = 32;

endpackage

//--- opn_prescaler.sv
/*
 * Clock enable prescaler. Divides the external cen level into the
 * internal clock enable and a one-clk strobe once per sample.
 */
module opn_prescaler #(
    parameter int PRESCALE     = opn_pkg::DEF_PRESCALE,
    parameter int SAMPLE_SLOTS = opn_pkg::DEF_SAMPLE_SLOTS
) (
    input  logic clk,
    input  logic rst_n,
    input  logic cen,
    output logic clk_en,
    output logic sample
);

    localparam int CW = (PRESCALE > 1) ? $clog2(PRESCALE) : 1;
    localparam int SW = (SAMPLE_SLOTS > 1) ? $clog2(SAMPLE_SLOTS) : 1;

    logic [CW-1:0] cen_cnt;
    logic [SW-1:0] slot_cnt;
    logic          cen_wrap;
    logic          slot_wrap;

    assign cen_wrap  = (cen_cnt == CW'(PRESCALE - 1));
    assign slot_wrap = (slot_cnt == SW'(SAMPLE_SLOTS - 1));

    // First stage counts cen cycles
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cen_cnt <= '0;
            clk_en  <= 1'b0;
        end else begin
            clk_en <= cen && cen_wrap;
            if (cen) begin
                cen_cnt <= cen_wrap ? '0 : cen_cnt + 1'b1;
            end
        end
    end

    // Slot counter stands in for the operator slot sequence
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            slot_cnt <= '0;
            sample   <= 1'b0;
        end else begin
            sample <= clk_en && slot_wrap;  // Once per full slot round
            if (clk_en) begin
                slot_cnt <= slot_wrap ? '0 : slot_cnt + 1'b1;
            end
        end
    end

endmodule

//--- opn_mmr.sv
/*
 * CPU bus decode and timer register file. A write at port 0 latches the
 * register number, a write at port 1 stores data into that register.
 * Drives the timer values, the control levels and the flag clear pulses.
 */
module opn_mmr (
    input  logic                 clk,
    input  logic                 rst_n,
    input  opn_pkg::cpu_data_t   din,
    input  opn_pkg::port_addr_t  addr,
    input  logic                 cs_n,
    input  logic                 wr_n,
    output logic                 data_wr,
    output opn_pkg::timer_a_t    value_a,
    output opn_pkg::timer_b_t    value_b,
    output logic                 load_a,
    output logic                 load_b,
    output logic                 en_flag_a,
    output logic                 en_flag_b,
    output logic                 clr_flag_a,
    output logic                 clr_flag_b
);

    import opn_pkg::*;

    reg_num_t reg_num;        // Latched register number
    logic     bus_wr;
    logic     num_wr;
    logic     dat_wr;
    logic     ctl_wr;

    assign bus_wr = !cs_n && !wr_n;  // No handshake, one write per clk
    assign num_wr = bus_wr && (addr == 2'd0);
    assign dat_wr = bus_wr && (addr == 2'd1);
    assign ctl_wr = dat_wr && (reg_num == REG_TIMER_CTL);

    // Register number latch
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            reg_num <= '0;
        end else if (num_wr) begin
            reg_num <= din;
        end
    end

    // Timer control register and write strobes
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            data_wr    <= 1'b0;
            load_a     <= 1'b0;
            load_b     <= 1'b0;
            en_flag_a  <= 1'b0;
            en_flag_b  <= 1'b0;
            clr_flag_a <= 1'b0;
            clr_flag_b <= 1'b0;
        end else begin
            data_wr    <= dat_wr;
            clr_flag_a <= ctl_wr && din[4];  // Clear bits act for one clk only
            clr_flag_b <= ctl_wr && din[5];
            if (ctl_wr) begin
                load_a    <= din[0];
                load_b    <= din[1];
                en_flag_a <= din[2];
                en_flag_b <= din[3];
            end
        end
    end

    // Timer value registers
    always_ff @(posedge clk) begin
        if (dat_wr) begin
            case (reg_num)
                REG_TIMER_A_HI: value_a[9:2] <= din;
                REG_TIMER_A_LO: value_a[1:0] <= din[1:0];  // Upper bits ignored
                REG_TIMER_B:    value_b      <= din;
                default: ;
            endcase
        end
    end

endmodule

//--- opn_timer.sv
/*
 * One up-counting timer with reload on overflow and an overflow flag.
 * TICK_DIV sample strobes make one count, so the same block serves as
 * timer A (TICK_DIV of 1) and timer B.
 */
module opn_timer #(
    parameter int WIDTH    = 8,
    parameter int TICK_DIV = 1
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             sample,
    input  logic [WIDTH-1:0] value,
    input  logic             load,
    input  logic             en_flag,
    input  logic             clr_flag,
    output logic             flag
);

    localparam int DW = (TICK_DIV > 1) ? $clog2(TICK_DIV) : 1;

    logic             load_q;
    logic             load_rise;
    logic [DW-1:0]    div_cnt;
    logic             div_wrap;
    logic             tick;
    logic             overflow;
    logic [WIDTH-1:0] cnt;

    assign load_rise = load && !load_q;
    assign div_wrap  = (div_cnt == DW'(TICK_DIV - 1));
    assign tick      = load && load_q && sample && div_wrap;  // No count in the load cycle
    assign overflow  = tick && (cnt == '1);  // Last count before reload

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            load_q  <= 1'b0;
            div_cnt <= '0;
            flag    <= 1'b0;
        end else begin
            load_q <= load;
            if (load_rise) begin
                div_cnt <= '0;  // Divider restarts with the counter
            end else if (load && sample) begin
                div_cnt <= div_wrap ? '0 : div_cnt + 1'b1;
            end
            if (clr_flag) begin
                flag <= 1'b0;  // Clear wins over a set
            end else if (overflow && en_flag) begin
                flag <= 1'b1;
            end
        end
    end

    // Counter holds while load is low
    always_ff @(posedge clk) begin
        if (load_rise) begin
            cnt <= value;
        end else if (tick) begin
            cnt <= overflow ? value : cnt + 1'b1;
        end
    end

endmodule

//--- opn_status.sv
/*
 * Status read and interrupt line. Keeps busy high for BUSY_CYCLES cen
 * cycles after each data write and returns busy and both timer flags
 * on any read.
 */
module opn_status #(
    parameter int BUSY_CYCLES = opn_pkg::DEF_BUSY_CYCLES
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               cen,
    input  logic               data_wr,
    input  logic               flag_a,
    input  logic               flag_b,
    output opn_pkg::cpu_data_t dout,
    output logic               irq_n
);

    localparam int BW = $clog2(BUSY_CYCLES + 1);

    logic [BW-1:0] busy_cnt;
    logic          busy;

    // Write cycle itself already shows busy
    assign busy = data_wr || (busy_cnt != '0);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy_cnt <= '0;
        end else if (data_wr) begin
            // Write cycle counts if cen was high in it
            busy_cnt <= cen ? BW'(BUSY_CYCLES - 1) : BW'(BUSY_CYCLES);
        end else if (cen && busy_cnt != '0) begin
            busy_cnt <= busy_cnt - 1'b1;
        end
    end

    assign dout  = {busy, 5'b00000, flag_b, flag_a};
    assign irq_n = !(flag_a || flag_b);  // Active low, either flag

endmodule

//--- opn_top.sv
/*
 * Control side of the FM sound chip. Connects the prescaler, the
 * register file, timers A and B and the status read. The CPU writes at
 * port 0 and 1; reads on any port return the status byte.
 */
module opn_top #(
    parameter int PRESCALE     = opn_pkg::DEF_PRESCALE,
    parameter int SAMPLE_SLOTS = opn_pkg::DEF_SAMPLE_SLOTS,
    parameter int TIMER_B_DIV  = opn_pkg::DEF_TIMER_B_DIV,
    parameter int BUSY_CYCLES  = opn_pkg::DEF_BUSY_CYCLES
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                cen,
    input  opn_pkg::cpu_data_t  din,
    input  opn_pkg::port_addr_t addr,
    input  logic                cs_n,
    input  logic                wr_n,
    output opn_pkg::cpu_data_t  dout,
    output logic                irq_n,
    output logic                sample
);

    import opn_pkg::*;

    logic     data_wr;
    timer_a_t value_a;
    timer_b_t value_b;
    logic     load_a;
    logic     load_b;
    logic     en_flag_a;
    logic     en_flag_b;
    logic     clr_flag_a;
    logic     clr_flag_b;
    logic     flag_a;
    logic     flag_b;

    opn_prescaler #(
        .PRESCALE     (PRESCALE),
        .SAMPLE_SLOTS (SAMPLE_SLOTS)
    ) u_prescaler (
        .clk    (clk),
        .rst_n  (rst_n),
        .cen    (cen),
        .clk_en (),         // Only the sample strobe leaves the prescaler
        .sample (sample)
    );

    opn_mmr u_mmr (
        .clk        (clk),
        .rst_n      (rst_n),
        .din        (din),
        .addr       (addr),
        .cs_n       (cs_n),
        .wr_n       (wr_n),
        .data_wr    (data_wr),
        .value_a    (value_a),
        .value_b    (value_b),
        .load_a     (load_a),
        .load_b     (load_b),
        .en_flag_a  (en_flag_a),
        .en_flag_b  (en_flag_b),
        .clr_flag_a (clr_flag_a),
        .clr_flag_b (clr_flag_b)
    );

    // Timer A counts every sample
    opn_timer #(
        .WIDTH    ($bits(timer_a_t)),
        .TICK_DIV (1)
    ) u_timer_a (
        .clk      (clk),
        .rst_n    (rst_n),
        .sample   (sample),
        .value    (value_a),
        .load     (load_a),
        .en_flag  (en_flag_a),
        .clr_flag (clr_flag_a),
        .flag     (flag_a)
    );

    opn_timer #(
        .WIDTH    ($bits(timer_b_t)),
        .TICK_DIV (TIMER_B_DIV)
    ) u_timer_b (
        .clk      (clk),
        .rst_n    (rst_n),
        .sample   (sample),
        .value    (value_b),
        .load     (load_b),
        .en_flag  (en_flag_b),
        .clr_flag (clr_flag_b),
        .flag     (flag_b)
    );

    opn_status #(
        .BUSY_CYCLES (BUSY_CYCLES)
    ) u_status (
        .clk     (clk),
        .rst_n   (rst_n),
        .cen     (cen),
        .data_wr (data_wr),
        .flag_a  (flag_a),
        .flag_b  (flag_b),
        .dout    (dout),
        .irq_n   (irq_n)
    );

endmodule

//--- opn_properties.sv
/*
 * Assertions for the FM chip control top level, bound to opn_top.
 * Check the status byte, the interrupt line, the busy time and the
 * sample strobe period. Timing rules assume cen is held high.
 */
module opn_properties #(
    parameter int BUSY_CYCLES = opn_pkg::DEF_BUSY_CYCLES,
    parameter int PERIOD      = opn_pkg::DEF_PRESCALE * opn_pkg::DEF_SAMPLE_SLOTS
) (
    input logic               clk,
    input logic               rst_n,
    input logic               data_wr,
    input logic               sample,
    input opn_pkg::cpu_data_t dout,
    input logic               irq_n
);
    timeunit 1ns;
    timeprecision 1ps;

    int   busy_len;        // Busy cycles seen since the last data write
    int   gap;             // Clocks since the last sample strobe
    logic gap_valid;
    int   fail_irq = 0;
    int   fail_zero = 0;
    int   fail_busy = 0;
    int   fail_period = 0;
    int   fail_count;

    assign fail_count = fail_irq + fail_zero + fail_busy + fail_period;

    // The write cycle itself is the first busy cycle
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy_len <= 0;
        end else if (data_wr) begin
            busy_len <= 1;
        end else if (dout[7]) begin
            busy_len <= busy_len + 1;
        end else begin
            busy_len <= 0;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            gap       <= 0;
            gap_valid <= 1'b0;   // No strobe seen yet
        end else if (sample) begin
            gap       <= 1;
            gap_valid <= 1'b1;
        end else begin
            gap <= gap + 1;
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n) irq_n == !(dout[1] || dout[0]))
        else begin
            fail_irq = fail_irq + 1;
            $error("irq_n does not match the status flags");
        end

    assert property (@(posedge clk) disable iff (!rst_n) dout[6:2] == 5'b00000)
        else begin
            fail_zero = fail_zero + 1;
            $error("status bits 6 to 2 are not zero");
        end

    // Busy too long while high, too short once it drops
    assert property (@(posedge clk) disable iff (!rst_n)
        busy_len != 0 |-> (dout[7] ? busy_len < BUSY_CYCLES : busy_len == BUSY_CYCLES))
        else begin
            fail_busy = fail_busy + 1;
            $error("busy lasted %0d cycles instead of %0d", busy_len, BUSY_CYCLES);
        end

    assert property (@(posedge clk) disable iff (!rst_n)
        gap_valid |-> (sample ? gap == PERIOD : gap < PERIOD))
        else begin
            fail_period = fail_period + 1;
            $error("sample strobe period is off, %0d clocks since last", gap);
        end

endmodule

bind opn_top opn_properties #(
    .BUSY_CYCLES (BUSY_CYCLES),
    .PERIOD      (PRESCALE * SAMPLE_SLOTS)
) u_props (
    .clk     (clk),
    .rst_n   (rst_n),
    .data_wr (data_wr),
    .sample  (sample),
    .dout    (dout),
    .irq_n   (irq_n)
);

//--- tb_opn.sv
/*
 * Testbench for the FM chip control top level. Writes the timer
 * registers over the CPU bus, waits on the status byte and checks
 * overflow timing, flag clear and busy length. The bound property
 * module watches the status and strobe rules on every clock.
 */
module tb_opn;
    timeunit 1ns;
    timeprecision 1ps;

    import opn_pkg::*;

    localparam int SAMPLE_PERIOD  = DEF_PRESCALE * DEF_SAMPLE_SLOTS;
    localparam int TIMEOUT_CYCLES = 40000;  // Longest timer B wait is under 7000

    logic       clk;
    logic       rst_n;
    logic       cen;
    cpu_data_t  din;
    port_addr_t addr;
    logic       cs_n;
    logic       wr_n;
    cpu_data_t  dout;
    logic       irq_n;
    logic       sample;

    int cycles;
    int err_count;
    int tests_run;
    int tests_failed;
    int test_errs;      // Error counts when the current test began
    int test_asserts;

    opn_top DUT (
        .clk    (clk),
        .rst_n  (rst_n),
        .cen    (cen),
        .din    (din),
        .addr   (addr),
        .cs_n   (cs_n),
        .wr_n   (wr_n),
        .dout   (dout),
        .irq_n  (irq_n),
        .sample (sample)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: tests did not finish within %0d clock cycles", TIMEOUT_CYCLES);
        $display("Testbench failed");
        $finish;
    end

    task automatic step_clock();
        @(posedge clk);
        #1;  // Drive and sample just after the edge
    endtask

    // Register number then data, returns in the first busy cycle
    task automatic bus_write(input reg_num_t num, input cpu_data_t data);
        cs_n = 1'b0;
        wr_n = 1'b0;
        addr = 2'd0;
        din  = num;
        step_clock();
        addr = 2'd1;
        din  = data;
        step_clock();
        cs_n = 1'b1;
        wr_n = 1'b1;
    endtask

    task automatic wait_not_busy(output int len);
        len = 0;
        while (dout[7]) begin
            len++;
            step_clock();
        end
    endtask

    task automatic write_reg(input reg_num_t num, input cpu_data_t data);
        int len;
        bus_write(num, data);
        wait_not_busy(len);
    endtask

    // Counts strobes from the load until a flag in mask shows up
    task automatic count_samples_to_flag(input cpu_data_t mask, output int n);
        n = 0;
        step_clock();  // Load cycle, its strobe is not counted
        while ((dout & mask) == 8'h00) begin
            if (sample) n++;
            step_clock();
        end
    endtask

    task automatic compare_value(input string name, input int expected, input int actual);
        if (expected != actual) begin
            $display("mismatch in test %s: expected %0d, actual %0d", name, expected, actual);
            err_count++;
        end
    endtask

    task automatic compare_range(input string name, input int expected, input int slack,
                                 input int actual);
        if (actual < expected - slack || actual > expected + slack) begin
            $display("mismatch in test %s: expected %0d (within %0d), actual %0d",
                     name, expected, slack, actual);
            err_count++;
        end
    endtask

    task automatic finish_test(input string name);
        int errs;
        errs = err_count - test_errs + DUT.u_props.fail_count - test_asserts;
        tests_run++;
        if (errs == 0) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: FAILED with %0d errors", name, errs);
        end
        test_errs    = err_count;
        test_asserts = DUT.u_props.fail_count;
    endtask

    initial begin
        int   n;
        int   v;
        int   w;
        logic seen;
        rst_n        = 1'b0;
        cen          = 1'b1;  // Held high for the whole run
        din          = '0;
        addr         = '0;
        cs_n         = 1'b1;
        wr_n         = 1'b1;
        err_count    = 0;
        tests_run    = 0;
        tests_failed = 0;
        test_errs    = 0;
        test_asserts = 0;
        void'($urandom(32'he29c));
        repeat (16) @(posedge clk);
        #1;
        rst_n = 1'b1;

        compare_value("reset", 0, int'(dout));
        compare_value("reset", 1, int'(irq_n));
        while (!sample) step_clock();
        n = 1;
        step_clock();
        while (!sample) begin
            n++;
            step_clock();
        end
        compare_value("reset", SAMPLE_PERIOD, n);
        finish_test("reset");

        bus_write(REG_TIMER_B, 8'h00);
        wait_not_busy(n);
        compare_value("busy", DEF_BUSY_CYCLES, n);
        bus_write(REG_TIMER_A_HI, 8'h00);
        wait_not_busy(n);
        compare_value("busy", DEF_BUSY_CYCLES, n);
        finish_test("busy");

        v = 1016 + int'($urandom % 7);
        write_reg(REG_TIMER_A_HI, cpu_data_t'(v >> 2));
        write_reg(REG_TIMER_A_LO, cpu_data_t'(v % 4));
        bus_write(REG_TIMER_CTL, 8'h05);  // Load A, flag A enabled
        count_samples_to_flag(8'h01, n);
        compare_range("timer_a", 1024 - v, 1, n);
        compare_value("timer_a", 0, int'(irq_n));
        finish_test("timer_a");

        compare_value("timer_a_off", 1, int'(dout[0]));
        write_reg(REG_TIMER_CTL, 8'h10);  // Clear A, timer A stops
        compare_value("timer_a_off", 0, int'(dout[1:0]));
        compare_value("timer_a_off", 1, int'(irq_n));
        bus_write(REG_TIMER_CTL, 8'h01);
        seen = 1'b0;
        n = 0;
        while (n < 10) begin   // Well past the timer A period
            step_clock();
            if (sample) n++;
            if (dout[1:0] != 2'b00 || !irq_n) seen = 1'b1;
        end
        compare_value("timer_a_off", 0, int'(seen));
        finish_test("timer_a_off");

        w = 253 + int'($urandom % 2);
        write_reg(REG_TIMER_B, cpu_data_t'(w));
        bus_write(REG_TIMER_CTL, 8'h0a);  // Load B, flag B enabled, A stopped
        count_samples_to_flag(8'h02, n);
        compare_range("timer_b", (256 - w) * DEF_TIMER_B_DIV, DEF_TIMER_B_DIV, n);
        compare_value("timer_b", 0, int'(irq_n));
        write_reg(REG_TIMER_CTL, 8'h20);
        compare_value("timer_b", 0, int'(dout[1:0]));
        compare_value("timer_b", 1, int'(irq_n));
        finish_test("timer_b");

        $display("tests run %0d, passed %0d, failed %0d, check errors %0d, assertion failures %0d",
                 tests_run, tests_run - tests_failed, tests_failed, err_count,
                 DUT.u_props.fail_count);
        if (err_count == 0 && DUT.u_props.fail_count == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

//--- compile.f
opn_pkg.sv
opn_prescaler.sv
opn_mmr.sv
opn_timer.sv
opn_status.sv
opn_top.sv
opn_properties.sv
tb_opn.sv

//--- run.sh
#!/bin/sh
# Build the testbench with Verilator, run it and judge the log
verilator --binary --timing --assert --timescale 1ns/1ps --top-module tb_opn \
    -f compile.f -o vsim_opn \
    || { echo "FAIL: build error"; exit 1; }
./obj_dir/vsim_opn +verilator+error+limit+1000 > sim.log 2>&1 \
    || { cat sim.log; echo "FAIL: simulator exited with an error"; exit 1; }
cat sim.log
grep -q "Testbench failed" sim.log && { echo "FAIL"; exit 1; } \
    || grep -q "Testbench passed" sim.log \
    || { echo "FAIL: no result in log"; exit 1; }
echo "PASS"
